/* verilog/ctrl_defs.svh */
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// ALU operation code width
`define ALU_CTRL_W 6

// N, Z, C, V, Q
`define ALU_FLAGS_W 5

// Condition field width, top of the instruction
`define COND_W 4

// Slice of the instruction the controller sees
`define INSTR_LO 12
`define INSTR_HI 31

`endif

/* verilog/ctrlPkg.sv */
`default_nettype none

`include "ctrl_defs.svh"

package ctrlPkg;

  typedef logic [`INSTR_HI:`INSTR_LO] instrT;    // Keeps real bit numbers
  typedef logic [`ALU_CTRL_W-1:0]     aluCtrlT;  // Top two bits give the class
  typedef logic [`ALU_FLAGS_W-1:0]    flagsT;    // N Z C V Q, MSB first
  typedef logic [`COND_W-1:0]         condT;
  typedef logic [1:0]                 selT;      // RegSrc and ImmSrc selects
  typedef logic [1:0]                 flagWrT;   // [1] N,Z  [0] C,V,Q

  // Decoded instruction class
  typedef enum logic [1:0] {
    clsMem    = 2'b00,
    clsBranch = 2'b01,
    clsData   = 2'b10
  } instrClassT;

  // Flag positions inside flagsT
  localparam int flagN = 4;
  localparam int flagZ = 3;
  localparam int flagC = 2;
  localparam int flagV = 1;
  localparam int flagQ = 0;

  // Operations that leave C, V and Q alone
  localparam aluCtrlT aluMul  = 6'b100111;
  localparam aluCtrlT aluSdiv = 6'b101111;
  localparam aluCtrlT aluMov  = 6'b111001;

endpackage

`default_nettype wire

/* verilog/condUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module condUnit (
  input  ctrlPkg::condT   CondE,
  input  ctrlPkg::flagsT  FlagsE,
  input  ctrlPkg::flagsT  ALUFlagsE,
  input  ctrlPkg::flagWrT FlagWriteE,
  output logic            CondExE,
  output ctrlPkg::flagsT  FlagsNextE
);
  import ctrlPkg::*;

  logic n;
  logic z;
  logic c;
  logic v;

  assign n = FlagsE[flagN];
  assign z = FlagsE[flagZ];
  assign c = FlagsE[flagC];
  assign v = FlagsE[flagV];

  always_comb begin
    case (CondE)
      4'b0000: CondExE = z;               // EQ
      4'b0001: CondExE = ~z;              // NE
      4'b0010: CondExE = c;               // CS
      4'b0011: CondExE = ~c;              // CC
      4'b0100: CondExE = n;               // MI
      4'b0101: CondExE = ~n;              // PL
      4'b0110: CondExE = v;               // VS
      4'b0111: CondExE = ~v;              // VC
      4'b1000: CondExE = c & ~z;          // HI
      4'b1001: CondExE = ~c | z;          // LS
      4'b1010: CondExE = (n == v);        // GE
      4'b1011: CondExE = (n != v);        // LT
      4'b1100: CondExE = ~z & (n == v);   // GT
      4'b1101: CondExE = z | (n != v);    // LE
      default: CondExE = 1'b1;            // AL, and 1111 as AL
    endcase
  end

  // A failed condition leaves every flag as it was
  always_comb begin
    FlagsNextE = FlagsE;
    if (FlagWriteE[1] && CondExE) begin
      FlagsNextE[flagN] = ALUFlagsE[flagN];
      FlagsNextE[flagZ] = ALUFlagsE[flagZ];
    end
    if (FlagWriteE[0] && CondExE) begin
      FlagsNextE[flagC] = ALUFlagsE[flagC];
      FlagsNextE[flagV] = ALUFlagsE[flagV];
      FlagsNextE[flagQ] = ALUFlagsE[flagQ];
    end
  end

endmodule

`default_nettype wire

/* verilog/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
  input  ctrlPkg::instrT   InstrD,
  output ctrlPkg::selT     RegSrcD,
  output ctrlPkg::selT     ImmSrcD,
  output logic             ALUSrcD,
  output logic             MemtoRegD,
  output logic             RegWriteD,
  output logic             MemWriteD,
  output logic             BranchD,
  output logic             PCSrcD,
  output ctrlPkg::aluCtrlT ALUControlD,
  output ctrlPkg::flagWrT  FlagWriteD
);
  import ctrlPkg::*;

  instrClassT instrClass;
  logic       isLoad;     // L bit of load/store
  logic       setsFlags;  // S bit of data processing
  logic [4:0] dpIndex;
  logic       dpValid;
  logic [3:0] memIndex;
  logic [1:0] brCode;
  logic       keepCvq;

  assign isLoad    = InstrD[20];
  assign setsFlags = InstrD[20];
  assign dpIndex   = {InstrD[26], InstrD[24:21]};
  assign dpValid   = (dpIndex != 5'b11111);  // All ones is unassigned
  assign memIndex  = InstrD[24:21];

  always_comb begin
    if (InstrD[27])
      instrClass = clsData;
    else if (InstrD[26])
      instrClass = clsBranch;
    else
      instrClass = clsMem;
  end

  // Per-class control table
  always_comb begin
    RegSrcD   = 2'b00;
    ImmSrcD   = 2'b00;
    ALUSrcD   = 1'b1;
    MemtoRegD = 1'b0;
    RegWriteD = 1'b0;
    MemWriteD = 1'b0;
    BranchD   = 1'b0;
    case (instrClass)
      clsData: begin
        ALUSrcD   = InstrD[25];  // Immediate operand
        RegWriteD = 1'b1;
      end
      clsBranch: begin
        RegSrcD   = 2'b01;
        ImmSrcD   = 2'b10;
        MemWriteD = 1'b1;
        BranchD   = 1'b1;
      end
      default: begin
        ImmSrcD = 2'b01;
        if (isLoad) begin
          MemtoRegD = 1'b1;
        end else begin
          RegSrcD   = 2'b10;
          RegWriteD = 1'b1;
          MemWriteD = 1'b1;
        end
      end
    endcase
  end

  // CBZ and CBNZ swap places relative to bits 25:24
  always_comb begin
    case (InstrD[25:24])
      2'b00:   brCode = 2'b00;  // B
      2'b01:   brCode = 2'b01;  // BL
      2'b11:   brCode = 2'b10;  // CBZ
      default: brCode = 2'b11;  // CBNZ
    endcase
  end

  always_comb begin
    ALUControlD = '0;  // Undefined encodings stay zero
    case (instrClass)
      clsData: begin
        if (dpValid)
          ALUControlD = {1'b1, dpIndex};
      end
      clsBranch: ALUControlD = {4'b0100, brCode};
      default: begin
        if (memIndex <= 4'd13)
          ALUControlD = {2'b00, memIndex} + 6'd2;
      end
    endcase
  end

  // Multiply, divide and MOV only touch N and Z
  assign keepCvq = ((ALUControlD >= aluMul) && (ALUControlD <= aluSdiv)) ||
                   (ALUControlD == aluMov);

  always_comb begin
    FlagWriteD = '0;
    if (instrClass == clsData && dpValid) begin
      FlagWriteD[1] = setsFlags;
      FlagWriteD[0] = setsFlags & ~keepCvq;
    end
  end

  // Write to R15 redirects the PC as well
  assign PCSrcD = ((InstrD[15:12] == 4'b1111) && RegWriteD) || BranchD;

endmodule

`default_nettype wire

/* verilog/stageCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

module stageCtrl (
  input  logic             clk,
  input  logic             rstN,
  input  ctrlPkg::condT    InstrCondD,
  input  logic             FlushE,
  input  logic             ALUSrcD,
  input  logic             MemtoRegD,
  input  logic             RegWriteD,
  input  logic             MemWriteD,
  input  logic             BranchD,
  input  logic             PCSrcD,
  input  ctrlPkg::aluCtrlT ALUControlD,
  input  ctrlPkg::flagWrT  FlagWriteD,
  input  ctrlPkg::flagsT   ALUFlagsE,
  output logic             ALUSrcE,
  output ctrlPkg::aluCtrlT ALUControlE,
  output logic             MemtoRegE,
  output logic             BranchTakenE,
  output logic             MemWriteM,
  output logic             RegWriteM,
  output logic             MemtoRegW,
  output logic             RegWriteW,
  output logic             PCSrcW,
  output logic             PCWrPendingF,
  output ctrlPkg::flagsT   FlagsE
);
  import ctrlPkg::*;

  flagWrT flagWriteE;
  logic   branchE;
  logic   memWriteE;
  logic   regWriteE;
  logic   pcSrcE;
  condT   condE;
  logic   condExE;
  flagsT  flagsNextE;
  logic   memtoRegM;
  logic   pcSrcM;

  // D to E, the bits a flush turns into a bubble
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flagWriteE <= '0;
      branchE    <= 1'b0;
      memWriteE  <= 1'b0;
      regWriteE  <= 1'b0;
      pcSrcE     <= 1'b0;
      MemtoRegE  <= 1'b0;
    end else if (FlushE) begin
      flagWriteE <= '0;
      branchE    <= 1'b0;
      memWriteE  <= 1'b0;
      regWriteE  <= 1'b0;
      pcSrcE     <= 1'b0;
      MemtoRegE  <= 1'b0;
    end else begin
      flagWriteE <= FlagWriteD;
      branchE    <= BranchD;
      memWriteE  <= MemWriteD;
      regWriteE  <= RegWriteD;
      pcSrcE     <= PCSrcD;
      MemtoRegE  <= MemtoRegD;
    end
  end

  // D to E, loads even under flush
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ALUSrcE     <= 1'b0;
      ALUControlE <= '0;
      condE       <= '0;
    end else begin
      ALUSrcE     <= ALUSrcD;
      ALUControlE <= ALUControlD;
      condE       <= InstrCondD;
    end
  end

  condUnit uCond (
    .CondE      (condE),
    .FlagsE     (FlagsE),
    .ALUFlagsE  (ALUFlagsE),
    .FlagWriteE (flagWriteE),
    .CondExE    (condExE),
    .FlagsNextE (flagsNextE)
  );

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      FlagsE <= '0;
    else
      FlagsE <= flagsNextE;  // Holds when nothing writes
  end

  // E to M with writes gated by the condition, then M to W
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      MemWriteM <= 1'b0;
      RegWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      pcSrcM    <= 1'b0;
      MemtoRegW <= 1'b0;
      RegWriteW <= 1'b0;
      PCSrcW    <= 1'b0;
    end else begin
      MemWriteM <= memWriteE & condExE;
      RegWriteM <= regWriteE & condExE;
      memtoRegM <= MemtoRegE;
      pcSrcM    <= pcSrcE & condExE;
      MemtoRegW <= memtoRegM;
      RegWriteW <= RegWriteM;
      PCSrcW    <= pcSrcM;
    end
  end

  assign BranchTakenE = branchE & condExE;

  // E term is ungated so fetch waits until the condition resolves
  assign PCWrPendingF = PCSrcD | pcSrcE | pcSrcM;

endmodule

`default_nettype wire

/* verilog/controller.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_defs.svh"

module controller (
  input  logic             clk,
  input  logic             rstN,
  input  ctrlPkg::instrT   InstrD,
  input  ctrlPkg::flagsT   ALUFlagsE,
  input  logic             FlushE,
  output ctrlPkg::selT     RegSrcD,
  output ctrlPkg::selT     ImmSrcD,
  output logic             ALUSrcE,
  output logic             BranchTakenE,
  output ctrlPkg::aluCtrlT ALUControlE,
  output logic             MemtoRegE,
  output logic             MemWriteM,
  output logic             RegWriteM,
  output logic             MemtoRegW,
  output logic             RegWriteW,
  output logic             PCSrcW,
  output logic             PCWrPendingF,
  output ctrlPkg::flagsT   FlagsE
);
  import ctrlPkg::*;

  logic    aluSrcD;
  logic    memtoRegD;
  logic    regWriteD;
  logic    memWriteD;
  logic    branchD;
  logic    pcSrcD;
  aluCtrlT aluControlD;
  flagWrT  flagWriteD;

  instrDecoder uDec (
    .InstrD      (InstrD),
    .RegSrcD     (RegSrcD),
    .ImmSrcD     (ImmSrcD),
    .ALUSrcD     (aluSrcD),
    .MemtoRegD   (memtoRegD),
    .RegWriteD   (regWriteD),
    .MemWriteD   (memWriteD),
    .BranchD     (branchD),
    .PCSrcD      (pcSrcD),
    .ALUControlD (aluControlD),
    .FlagWriteD  (flagWriteD)
  );

  stageCtrl uStage (
    .clk          (clk),
    .rstN         (rstN),
    .InstrCondD   (InstrD[`INSTR_HI -: `COND_W]),  // Condition field
    .FlushE       (FlushE),
    .ALUSrcD      (aluSrcD),
    .MemtoRegD    (memtoRegD),
    .RegWriteD    (regWriteD),
    .MemWriteD    (memWriteD),
    .BranchD      (branchD),
    .PCSrcD       (pcSrcD),
    .ALUControlD  (aluControlD),
    .FlagWriteD   (flagWriteD),
    .ALUFlagsE    (ALUFlagsE),
    .ALUSrcE      (ALUSrcE),
    .ALUControlE  (ALUControlE),
    .MemtoRegE    (MemtoRegE),
    .BranchTakenE (BranchTakenE),
    .MemWriteM    (MemWriteM),
    .RegWriteM    (RegWriteM),
    .MemtoRegW    (MemtoRegW),
    .RegWriteW    (RegWriteW),
    .PCSrcW       (PCSrcW),
    .PCWrPendingF (PCWrPendingF),
    .FlagsE       (FlagsE)
  );

endmodule

`default_nettype wire

/* bench/controllerTb.sv */
`timescale 1ns/10ps
`default_nettype none

module controllerTb;
  import ctrlPkg::*;

  localparam instrT loadAl = 20'hE0100;  // LDR with AL and no PC or flag effect

  logic        clk = 1'b0;
  logic        rstN;
  instrT       InstrD;
  flagsT       ALUFlagsE;
  logic        FlushE;
  selT         RegSrcD;
  selT         ImmSrcD;
  logic        ALUSrcE;
  logic        BranchTakenE;
  aluCtrlT     ALUControlE;
  logic        MemtoRegE;
  logic        MemWriteM;
  logic        RegWriteM;
  logic        MemtoRegW;
  logic        RegWriteW;
  logic        PCSrcW;
  logic        PCWrPendingF;
  flagsT       FlagsE;

  // Reference pipeline state
  logic        eAluSrc;
  aluCtrlT     eAluCtrl;
  logic        eMemtoReg;
  logic        eBranch;
  logic        eMemWrite;
  logic        eRegWrite;
  logic        ePcSrc;
  flagWrT      eFlagWr;
  condT        eCond;
  flagsT       eFlags;
  logic        mMemWrite;
  logic        mRegWrite;
  logic        mMemtoReg;
  logic        mPcSrc;
  logic        wMemtoReg;
  logic        wRegWrite;
  logic        wPcSrc;
  logic [17:0] dRef;   // regSrc immSrc aluSrc memtoReg regWrite memWrite branch pcSrc code fw
  logic        condOk;

  controller i_dut (.*);

  initial begin
    forever #2 clk = ~clk;
  end

  initial begin
    #20000;
    failRun("Simulation did not finish within its time limit");
  end

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string what);
    failRun($sformatf("ERROR @ %0t ns: %s", $time, what));
  endtask

  task automatic compareField(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else
      failRun($sformatf("ERROR @ %0t ns: %s is %0h, expected %0h", $time, name, got, exp));
  endtask

  function automatic logic [17:0] decodeRef(input instrT i);
    logic [4:0] idx;
    aluCtrlT    code;
    logic [8:0] tbl;  // regSrc immSrc aluSrc memtoReg regWrite memWrite branch
    flagWrT     fw;
    logic       pc;
    fw = 2'b00;
    if (i[27]) begin
      idx  = {i[26], i[24:21]};
      code = (idx == 5'h1f) ? 6'd0 : {1'b1, idx};
      tbl  = {2'b00, 2'b00, i[25], 1'b0, 1'b1, 1'b0, 1'b0};
      if (code != 6'd0)
        fw = {i[20], i[20] && !((code >= 6'd39 && code <= 6'd47) || code == 6'd57)};
    end else if (i[26]) begin
      code = {4'b0100, i[25], i[25] ^ i[24]};  // B BL CBZ CBNZ
      tbl  = {2'b01, 2'b10, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1};
    end else begin
      code = (i[24:21] <= 4'd13) ? ({2'b00, i[24:21]} + 6'd2) : 6'd0;
      if (i[20])
        tbl = {2'b00, 2'b01, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
      else
        tbl = {2'b10, 2'b01, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
    end
    pc = (tbl[2] && i[15:12] == 4'hf) || tbl[0];
    return {tbl, pc, code, fw};
  endfunction

  function automatic logic condRef(input condT cond, input flagsT f);
    logic n;
    logic z;
    logic c;
    logic v;
    logic ok;
    {n, z, c, v} = f[4:1];
    case (cond)
      4'h0: ok = z;
      4'h1: ok = !z;
      4'h2: ok = c;
      4'h3: ok = !c;
      4'h4: ok = n;
      4'h5: ok = !n;
      4'h6: ok = v;
      4'h7: ok = !v;
      4'h8: ok = c && !z;
      4'h9: ok = !c || z;
      4'ha: ok = (n == v);
      4'hb: ok = (n != v);
      4'hc: ok = !z && (n == v);
      4'hd: ok = z || (n != v);
      default: ok = 1'b1;
    endcase
    return ok;
  endfunction

  function automatic flagsT mergeFlags(input flagsT cur, input flagsT alu, input flagWrT fw,
                                       input logic ok);
    flagsT nxt;
    nxt = cur;
    if (ok && fw[1])
      nxt[4:3] = alu[4:3];  // N Z
    if (ok && fw[0])
      nxt[2:0] = alu[2:0];  // C V Q
    return nxt;
  endfunction

  function automatic instrT buildInstr(input condT cond, input logic b27, input logic b26,
                                       input logic b25, input logic [3:0] op, input logic s,
                                       input logic [3:0] rd);
    return {cond, b27, b26, b25, op, s, 4'h0, rd};
  endfunction

  assign dRef   = decodeRef(InstrD);
  assign condOk = condRef(eCond, eFlags);

  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {eAluSrc, eAluCtrl, eMemtoReg, eBranch, eMemWrite, eRegWrite, ePcSrc, eFlagWr} <= '0;
      {eCond, eFlags, mMemWrite, mRegWrite, mMemtoReg, mPcSrc} <= '0;
      {wMemtoReg, wRegWrite, wPcSrc} <= '0;
    end else begin
      eAluSrc  <= dRef[13];
      eAluCtrl <= dRef[7:2];
      eCond    <= InstrD[31:28];
      if (FlushE)
        {eMemtoReg, eRegWrite, eMemWrite, eBranch, ePcSrc, eFlagWr} <= '0;
      else
        {eMemtoReg, eRegWrite, eMemWrite, eBranch, ePcSrc, eFlagWr} <= {dRef[12:8], dRef[1:0]};
      eFlags    <= mergeFlags(eFlags, ALUFlagsE, eFlagWr, condOk);
      mMemWrite <= eMemWrite & condOk;
      mRegWrite <= eRegWrite & condOk;
      mMemtoReg <= eMemtoReg;
      mPcSrc    <= ePcSrc & condOk;
      wMemtoReg <= mMemtoReg;
      wRegWrite <= mRegWrite;
      wPcSrc    <= mPcSrc;
    end
  end

  // Outputs settle by the falling edge
  always @(negedge clk) begin
    if (!rstN)
      assert ({ALUSrcE, ALUControlE, MemtoRegE, MemWriteM, RegWriteM, MemtoRegW, RegWriteW,
               PCSrcW, FlagsE, BranchTakenE} == '0) else
        failRun($sformatf("ERROR @ %0t ns: registered outputs not zero in reset", $time));
    compareField("RegSrcD", RegSrcD, dRef[17:16]);
    compareField("ImmSrcD", ImmSrcD, dRef[15:14]);
    compareField("ALUSrcE", ALUSrcE, eAluSrc);
    compareField("ALUControlE", ALUControlE, eAluCtrl);
    compareField("MemtoRegE", MemtoRegE, eMemtoReg);
    compareField("BranchTakenE", BranchTakenE, eBranch & condOk);
    compareField("FlagsE", FlagsE, eFlags);
    compareField("MemWriteM", MemWriteM, mMemWrite);
    compareField("RegWriteM", RegWriteM, mRegWrite);
    compareField("MemtoRegW", MemtoRegW, wMemtoReg);
    compareField("RegWriteW", RegWriteW, wRegWrite);
    compareField("PCSrcW", PCSrcW, wPcSrc);
    compareField("PCWrPendingF", PCWrPendingF, dRef[8] | ePcSrc | mPcSrc);
  end

  task automatic issue(input instrT instr, input flagsT aluFl, input logic flush);
    @(posedge clk);
    InstrD    <= instr;
    ALUFlagsE <= aluFl;
    FlushE    <= flush;
  endtask

  // Follows one PC-writing instruction down to W
  task automatic checkPcWrite(input instrT instr, input logic expectW);
    int   edges;
    logic seen;
    edges = 0;
    seen  = 1'b0;
    issue(instr, 5'h00, 1'b0);
    @(negedge clk);
    assert (PCWrPendingF) else reportMismatch("PCWrPendingF stayed low with a PC write in D");
    while (!seen && edges < 8) begin
      issue(loadAl, 5'h00, 1'b0);
      edges++;
      @(negedge clk);
      if (edges == 1 || (edges == 2 && expectW))
        assert (PCWrPendingF) else
          reportMismatch("PCWrPendingF dropped before the PC write left M");
      if (PCSrcW)
        seen = 1'b1;
    end
    if (expectW) begin
      assert (seen && edges == 3) else reportMismatch("PCSrcW did not rise three edges after D");
    end else begin
      assert (!seen) else reportMismatch("PCSrcW rose although the condition failed");
    end
  endtask

  task automatic checkFlush();
    flagsT held;
    int    k;
    repeat (2) issue(loadAl, 5'h00, 1'b0);
    @(negedge clk);
    held = FlagsE;
    issue(buildInstr(4'he, 1'b1, 1'b0, 1'b1, 4'h4, 1'b1, 4'hf), 5'h00, 1'b1);  // ADDS to R15
    issue(buildInstr(4'he, 1'b0, 1'b1, 1'b0, 4'h0, 1'b0, 4'h0), ~held, 1'b1);  // B
    issue(loadAl, ~held, 1'b0);  // Would change every flag
    for (k = 0; k < 4; k++) begin
      @(negedge clk);
      assert (!BranchTakenE && !RegWriteM && !MemWriteM && !RegWriteW && !PCSrcW)
        else reportMismatch("A flushed instruction still caused a write");
      assert (FlagsE == held) else reportMismatch("A flushed instruction changed the flags");
    end
  endtask

  initial begin
    int          k;
    logic [31:0] rndA;
    logic [31:0] rndB;
    rndA = $urandom(32'h1a9a_2260);
    rstN      = 1'b0;
    InstrD    = '0;
    ALUFlagsE = '0;
    FlushE    = 1'b0;
    for (k = 0; k < 4; k++) begin
      rndA = $urandom;
      rndB = $urandom;
      issue(rndA[31:12], rndB[4:0], 1'b0);
      if (k == 3)
        rstN <= 1'b1;  // Sampled low on this fourth edge
    end
    // Preload flags with MOVS then ADDS
    issue(buildInstr(4'he, 1'b1, 1'b1, 1'b0, 4'h9, 1'b1, 4'h0), 5'h00, 1'b0);
    issue(buildInstr(4'he, 1'b1, 1'b0, 1'b0, 4'h4, 1'b1, 4'h1), 5'h1f, 1'b0);
    issue(loadAl, 5'h0a, 1'b0);
    for (k = 0; k < 600; k++) begin
      rndA = $urandom;
      rndB = $urandom;
      issue(rndA[31:12], rndB[4:0], rndB[10:8] == 3'b000);
    end
    checkFlush();
    checkPcWrite(buildInstr(4'he, 1'b0, 1'b1, 1'b0, 4'h0, 1'b0, 4'h0), 1'b1);  // B
    checkPcWrite(buildInstr(4'he, 1'b1, 1'b0, 1'b1, 4'h4, 1'b0, 4'hf), 1'b1);  // ADD to R15
    repeat (2) issue(loadAl, 5'h00, 1'b0);
    @(negedge clk);
    // EQ or NE picked so that it fails on the current Z
    checkPcWrite(buildInstr(FlagsE[3] ? 4'h1 : 4'h0, 1'b1, 1'b0, 1'b1, 4'h4, 1'b0, 4'hf), 1'b0);
    repeat (4) issue(loadAl, 5'h00, 1'b0);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/ctrlPkg.sv
verilog/condUnit.sv
verilog/instrDecoder.sv
verilog/stageCtrl.sv
verilog/controller.sv
bench/controllerTb.sv
